// File: design/vec_cfg_pkg.sv
// Vector unit sizing
`default_nettype none

package vec_cfg_pkg;

  //////////////////////////////
  // Sizing
  //////////////////////////////

  localparam int unsigned nr_lanes = 4;
  localparam int unsigned elem_width = 16;
  localparam int unsigned nr_vregs = 8;
  localparam int unsigned max_vl = 16;

  // Each lane holds a slice of every register
  localparam int unsigned rows_per_lane = max_vl / nr_lanes;

  //////////////////////////////
  // Types
  //////////////////////////////

  // One element
  typedef logic [elem_width-1:0] elem_t;

  // Vector register number
  typedef logic [$clog2(nr_vregs)-1:0] vreg_idx_t;

  // Row within a lane slice
  typedef logic [$clog2(rows_per_lane)-1:0] row_idx_t;

  // Element count, 0 up to max_vl inclusive
  typedef logic [$clog2(max_vl+1)-1:0] vl_t;

endpackage

`default_nettype wire

// File: design/vec_insn_pkg.sv
// Vector instruction types
`default_nettype none

package vec_insn_pkg;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  typedef enum logic [3:0] {
    OP_SETVL   = 4'h0,
    OP_SPLAT   = 4'h1,
    OP_ADD_VV  = 4'h2,
    OP_SUB_VV  = 4'h3,
    OP_AND_VV  = 4'h4,
    OP_XOR_VV  = 4'h5,
    OP_ADD_VX  = 4'h6,
    OP_EXTRACT = 4'h7,
    OP_REDSUM  = 4'h8
  } vec_op_e;

  //////////////////////////////
  // Host port
  //////////////////////////////

  typedef struct packed {
    vec_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    // Splat value, vl request or element index
    vec_cfg_pkg::elem_t     scalar;
  } host_cmd_t;

  typedef struct packed {
    vec_cfg_pkg::elem_t data;
    vec_cfg_pkg::vl_t   vl;
  } host_resp_t;

  //////////////////////////////
  // Lane port
  //////////////////////////////

  // One element group, broadcast to all lanes
  typedef struct packed {
    vec_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    vec_cfg_pkg::row_idx_t  row;
    vec_cfg_pkg::elem_t     scalar;
  } lane_req_t;

  typedef struct packed {
    logic               valid;
    vec_cfg_pkg::elem_t data;
  } lane_resp_t;

endpackage

`default_nettype wire

// File: design/vec_csr.sv
// Vector length register
`default_nettype none
`timescale 1ns/10ps

module vec_csr (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               vl_we_i,
  input  vec_cfg_pkg::elem_t vl_req_i,
  output vec_cfg_pkg::vl_t   vl_o
);

  vec_cfg_pkg::vl_t vl_q;
  vec_cfg_pkg::vl_t vl_clip;

  // Requests beyond the register size saturate
  always_comb begin
    if (vl_req_i > vec_cfg_pkg::elem_t'(vec_cfg_pkg::max_vl)) begin
      vl_clip = vec_cfg_pkg::vl_t'(vec_cfg_pkg::max_vl);
    end else begin
      vl_clip = vec_cfg_pkg::vl_t'(vl_req_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      vl_q <= vec_cfg_pkg::vl_t'(vec_cfg_pkg::max_vl);
    end else if (vl_we_i) begin
      vl_q <= vl_clip;
    end
  end

  assign vl_o = vl_q;

  // Sequencer row math relies on this bound
  a_vl_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    vl_o <= vec_cfg_pkg::vl_t'(vec_cfg_pkg::max_vl)
  );

endmodule

`default_nettype wire

// File: design/vec_dispatcher.sv
// Host handshake and decode
`default_nettype none
`timescale 1ns/10ps

module vec_dispatcher (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  vec_insn_pkg::host_cmd_t  cmd_i,
  output logic                     ack_o,
  output vec_insn_pkg::host_resp_t resp_o,
  input  vec_cfg_pkg::vl_t         vl_i,
  output logic                     vl_we_o,
  output vec_cfg_pkg::elem_t       vl_req_o,
  output logic                     start_o,
  output vec_insn_pkg::host_cmd_t  insn_o,
  input  logic                     done_i,
  input  vec_cfg_pkg::elem_t       result_i
);

  typedef enum logic [2:0] {IDLE, EXEC, SETVL, ACK, RELEASE} disp_state_e;

  disp_state_e             state_q, state_d;
  logic                    start_q;
  vec_insn_pkg::host_cmd_t cmd_q;
  vec_cfg_pkg::elem_t      data_q;
  logic                    scalar_op;
  logic                    accept;

  assign accept = (state_q == IDLE) && req_i;
  assign scalar_op = (cmd_q.op == vec_insn_pkg::OP_EXTRACT) ||
                     (cmd_q.op == vec_insn_pkg::OP_REDSUM);

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          if (cmd_i.op == vec_insn_pkg::OP_SETVL) begin
            state_d = SETVL;
          end else begin
            state_d = EXEC;
          end
        end
      end
      EXEC:    if (done_i) state_d = ACK;
      SETVL:   state_d = ACK;
      // Hold the response until the host lets go of req
      ACK:     if (!req_i) state_d = RELEASE;
      RELEASE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= accept && (cmd_i.op != vec_insn_pkg::OP_SETVL);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
    if ((state_q == EXEC) && done_i) begin
      data_q <= scalar_op ? result_i : '0;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign ack_o    = (state_q == ACK);
  assign vl_we_o  = (state_q == SETVL);
  assign vl_req_o = cmd_q.scalar;
  assign start_o  = start_q;
  assign insn_o   = cmd_q;

  // New vl is already visible once ACK is reached
  assign resp_o.data = (cmd_q.op == vec_insn_pkg::OP_SETVL) ? vec_cfg_pkg::elem_t'(vl_i) : data_q;
  assign resp_o.vl   = vl_i;

  a_ack_needs_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> req_i
  );

endmodule

`default_nettype wire

// File: design/vec_sequencer.sv
// Element group sequencer
`default_nettype none
`timescale 1ns/10ps

module vec_sequencer (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  logic                                                 start_i,
  input  vec_insn_pkg::host_cmd_t                              insn_i,
  input  vec_cfg_pkg::vl_t                                     vl_i,
  output vec_insn_pkg::lane_req_t                              lane_req_o,
  output logic                    [vec_cfg_pkg::nr_lanes-1:0]  lane_en_o,
  input  vec_insn_pkg::lane_resp_t [vec_cfg_pkg::nr_lanes-1:0] lane_resp_i,
  output logic                                                 done_o,
  output vec_cfg_pkg::elem_t                                   result_o
);

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT, SEQ_DONE} seq_state_e;

  seq_state_e              state_q, state_d;
  vec_insn_pkg::host_cmd_t cmd_q;
  vec_cfg_pkg::row_idx_t   row_q, last_row_q;
  vec_cfg_pkg::elem_t      acc_q, acc_d;
  logic                    is_extract;
  logic                    skip;
  logic                    scalar_op;

  assign is_extract = (insn_i.op == vec_insn_pkg::OP_EXTRACT);
  // Nothing to issue: empty vector or extract past vl
  assign skip = (vl_i == '0) ||
                (is_extract && (insn_i.scalar >= vec_cfg_pkg::elem_t'(vl_i)));
  assign scalar_op = (cmd_q.op == vec_insn_pkg::OP_EXTRACT) ||
                     (cmd_q.op == vec_insn_pkg::OP_REDSUM);

  //////////////////////////////
  // Row walk
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (start_i) begin
          state_d = skip ? SEQ_DONE : SEQ_ISSUE;
        end
      end
      SEQ_ISSUE: if (row_q == last_row_q) state_d = SEQ_WAIT;
      SEQ_WAIT:  state_d = SEQ_DONE;
      default:   state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == SEQ_IDLE) && start_i) begin
      cmd_q <= insn_i;
      acc_q <= '0;
      if (is_extract) begin
        row_q      <= vec_cfg_pkg::row_idx_t'(insn_i.scalar / vec_cfg_pkg::nr_lanes);
        last_row_q <= vec_cfg_pkg::row_idx_t'(insn_i.scalar / vec_cfg_pkg::nr_lanes);
      end else begin
        row_q      <= '0;
        last_row_q <= vec_cfg_pkg::row_idx_t'((int'(vl_i) - 1) / vec_cfg_pkg::nr_lanes);
      end
    end else begin
      acc_q <= acc_d;
      if (state_q == SEQ_ISSUE) begin
        row_q <= row_q + 1'b1;
      end
    end
  end

  // Lane enables for the current row
  always_comb begin
    lane_en_o = '0;
    if (state_q == SEQ_ISSUE) begin
      for (int l = 0; l < vec_cfg_pkg::nr_lanes; l++) begin
        if (cmd_q.op == vec_insn_pkg::OP_EXTRACT) begin
          lane_en_o[l] = (cmd_q.scalar % vec_cfg_pkg::nr_lanes) == l;
        end else begin
          lane_en_o[l] = (int'(row_q) * vec_cfg_pkg::nr_lanes + l) < int'(vl_i);
        end
      end
    end
  end

  always_comb begin
    lane_req_o.op     = cmd_q.op;
    lane_req_o.vd     = cmd_q.vd;
    lane_req_o.vs1    = cmd_q.vs1;
    lane_req_o.vs2    = cmd_q.vs2;
    lane_req_o.row    = row_q;
    lane_req_o.scalar = cmd_q.scalar;
  end

  //////////////////////////////
  // Scalar result
  //////////////////////////////

  // Extract enables a single lane, so the sum is that element
  always_comb begin
    acc_d = acc_q;
    if (scalar_op) begin
      for (int l = 0; l < vec_cfg_pkg::nr_lanes; l++) begin
        if (lane_resp_i[l].valid) acc_d = acc_d + lane_resp_i[l].data;
      end
    end
  end

  assign done_o   = (state_q == SEQ_DONE);
  assign result_o = acc_q;

  a_no_issue_idle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_q == SEQ_IDLE) |-> (lane_en_o == '0)
  );

endmodule

`default_nettype wire

// File: design/vec_lane.sv
// Vector lane with register slice and ALU
`default_nettype none
`timescale 1ns/10ps

module vec_lane (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  vec_insn_pkg::lane_req_t  lane_req_i,
  input  logic                     lane_en_i,
  output vec_insn_pkg::lane_resp_t lane_resp_o
);

  // Register slice, indexed by register then row
  vec_cfg_pkg::elem_t vrf_q [vec_cfg_pkg::nr_vregs][vec_cfg_pkg::rows_per_lane];

  vec_cfg_pkg::elem_t     op_a;
  vec_cfg_pkg::elem_t     op_b;
  vec_cfg_pkg::elem_t     alu_res;
  logic                   is_write;
  logic                   wb_valid_q;
  logic                   wb_we_q;
  vec_cfg_pkg::vreg_idx_t wb_vd_q;
  vec_cfg_pkg::row_idx_t  wb_row_q;
  vec_cfg_pkg::elem_t     wb_res_q;
  vec_cfg_pkg::elem_t     wb_src_q;

  //////////////////////////////
  // Issue stage
  //////////////////////////////

  assign op_a = vrf_q[lane_req_i.vs1][lane_req_i.row];
  assign op_b = vrf_q[lane_req_i.vs2][lane_req_i.row];

  // Integer ALU, all arithmetic wraps at 16 bits
  always_comb begin
    is_write = 1'b1;
    case (lane_req_i.op)
      vec_insn_pkg::OP_SPLAT:  alu_res = lane_req_i.scalar;
      vec_insn_pkg::OP_ADD_VV: alu_res = op_b + op_a;
      vec_insn_pkg::OP_SUB_VV: alu_res = op_b - op_a;
      vec_insn_pkg::OP_AND_VV: alu_res = op_b & op_a;
      vec_insn_pkg::OP_XOR_VV: alu_res = op_b ^ op_a;
      vec_insn_pkg::OP_ADD_VX: alu_res = op_b + lane_req_i.scalar;
      default: begin
        // Extract and reduction only read vs2
        alu_res  = op_b;
        is_write = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Write-back stage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_valid_q <= 1'b0;
      wb_we_q    <= 1'b0;
    end else begin
      wb_valid_q <= lane_en_i;
      wb_we_q    <= lane_en_i && is_write;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_en_i) begin
      wb_vd_q  <= lane_req_i.vd;
      wb_row_q <= lane_req_i.row;
      wb_res_q <= alu_res;
      wb_src_q <= op_b;
    end
  end

  // Disabled rows are never written, which keeps the tail intact
  always_ff @(posedge clk_i) begin
    if (wb_we_q) begin
      vrf_q[wb_vd_q][wb_row_q] <= wb_res_q;
    end
  end

  assign lane_resp_o.valid = wb_valid_q;
  assign lane_resp_o.data  = wb_src_q;

  a_we_after_en: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_we_q |-> $past(lane_en_i)
  );

endmodule

`default_nettype wire

// File: design/vec_top.sv
// Vector coprocessor top level
`default_nettype none
`timescale 1ns/10ps

module vec_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  vec_insn_pkg::host_cmd_t  cmd_i,
  output logic                     ack_o,
  output vec_insn_pkg::host_resp_t resp_o
);

  vec_cfg_pkg::vl_t                                      vl;
  logic                                                  vl_we;
  vec_cfg_pkg::elem_t                                    vl_req;
  logic                                                  start;
  vec_insn_pkg::host_cmd_t                               insn;
  logic                                                  done;
  vec_cfg_pkg::elem_t                                    result;
  vec_insn_pkg::lane_req_t                               lane_req;
  logic                     [vec_cfg_pkg::nr_lanes-1:0]  lane_en;
  vec_insn_pkg::lane_resp_t [vec_cfg_pkg::nr_lanes-1:0]  lane_resp;

  //////////////////////////////
  // Front end
  //////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .req_i   (req_i  ),
    .cmd_i   (cmd_i  ),
    .ack_o   (ack_o  ),
    .resp_o  (resp_o ),
    .vl_i    (vl     ),
    .vl_we_o (vl_we  ),
    .vl_req_o(vl_req ),
    .start_o (start  ),
    .insn_o  (insn   ),
    .done_i  (done   ),
    .result_i(result )
  );

  vec_csr i_csr (.clk_i(clk_i), .rst_n_i(rst_n_i), .vl_we_i(vl_we), .vl_req_i(vl_req), .vl_o(vl));

  vec_sequencer i_sequencer (
    .clk_i      (clk_i    ),
    .rst_n_i    (rst_n_i  ),
    .start_i    (start    ),
    .insn_i     (insn     ),
    .vl_i       (vl       ),
    .lane_req_o (lane_req ),
    .lane_en_o  (lane_en  ),
    .lane_resp_i(lane_resp),
    .done_o     (done     ),
    .result_o   (result   )
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  for (genvar l = 0; l < vec_cfg_pkg::nr_lanes; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i      (clk_i       ),
      .rst_n_i    (rst_n_i     ),
      .lane_req_i (lane_req    ),
      .lane_en_i  (lane_en[l]  ),
      .lane_resp_o(lane_resp[l])
    );
  end

endmodule

`default_nettype wire

// File: bench/tb_vec_top.sv
// Vector coprocessor testbench
`default_nettype none
`timescale 1ns/10ps

module tb_vec_top;

  localparam int clk_period        = 100;
  localparam int reset_cycles      = 8;
  localparam int vec_fields        = 7;
  localparam int max_vectors       = 64;
  localparam int cycles_per_vector = 64;
  localparam int ack_limit         = 48;
  localparam logic [15:0] end_marker = 16'h000f;

  logic                     clk;
  logic                     rst_n;
  logic                     req;
  vec_insn_pkg::host_cmd_t  cmd;
  logic                     ack;
  vec_insn_pkg::host_resp_t resp;

  logic [15:0] vec_mem [max_vectors*vec_fields];
  int          nr_vectors;
  logic        loaded;
  logic        in_handshake;
  integer      seed;
  int          value_errors;
  int          other_errors;
  int          stray_acks;

  vec_top dut_i (
    .clk_i  (clk  ),
    .rst_n_i(rst_n),
    .req_i  (req  ),
    .cmd_i  (cmd  ),
    .ack_o  (ack  ),
    .resp_o (resp )
  );

  //////////////////////////////
  // Clock and vector file
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  initial begin
    loaded = 1'b0;
    $readmemh("bench/vec_vectors.txt", vec_mem);
    nr_vectors = 0;
    while ((nr_vectors < max_vectors) &&
           (vec_mem[nr_vectors*vec_fields] != end_marker)) begin
      nr_vectors++;
    end
    loaded = 1'b1;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_data(input string name, input vec_cfg_pkg::elem_t got,
                            input vec_cfg_pkg::elem_t exp, input int idx);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h (vector %0d)", name, got, exp, idx);
      value_errors++;
    end
  endtask

  task automatic check_vl(input string name, input vec_cfg_pkg::vl_t got,
                          input vec_cfg_pkg::vl_t exp, input int idx);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h (vector %0d)", name, got, exp, idx);
      value_errors++;
    end
  endtask

  task automatic print_counts();
    $display("Errors: %0d value, %0d protocol, %0d stray ack", value_errors, other_errors,
             stray_acks);
  endtask

  // Ack must only show up while a request is outstanding
  always @(negedge clk) begin
    if (rst_n && ack && !in_handshake) begin
      $display("Stray ack: ack_o is high with no request outstanding");
      stray_acks++;
    end
  end

  //////////////////////////////
  // Host driver
  //////////////////////////////

  task automatic wait_ack(input logic level, input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((ack !== level) && (cycles < ack_limit)) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== level) begin
      $display("Vector %0d: ack_o never reached %0b within %0d cycles", idx, level, ack_limit);
      other_errors++;
    end
  endtask

  task automatic apply_vector(input int idx);
    vec_insn_pkg::host_cmd_t c;
    vec_cfg_pkg::elem_t      exp_data;
    vec_cfg_pkg::vl_t        exp_vl;
    int                      base;
    int                      gap;
    int                      hold;
    base       = idx * vec_fields;
    c.op       = vec_insn_pkg::vec_op_e'(vec_mem[base][3:0]);
    c.vd       = vec_cfg_pkg::vreg_idx_t'(vec_mem[base+1]);
    c.vs1      = vec_cfg_pkg::vreg_idx_t'(vec_mem[base+2]);
    c.vs2      = vec_cfg_pkg::vreg_idx_t'(vec_mem[base+3]);
    c.scalar   = vec_mem[base+4];
    exp_data   = vec_mem[base+5];
    exp_vl     = vec_cfg_pkg::vl_t'(vec_mem[base+6]);
    gap        = $unsigned($random(seed)) % 4;
    hold       = $unsigned($random(seed)) % 4;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    cmd          <= c;
    req          <= 1'b1;
    in_handshake = 1'b1;
    wait_ack(1'b1, idx);
    check_data("resp_o.data", resp.data, exp_data, idx);
    check_vl("resp_o.vl", resp.vl, exp_vl, idx);
    // Extra cycles with req still high must not start anything new
    repeat (hold) begin
      @(negedge clk);
      if (ack !== 1'b1) begin
        $display("Vector %0d: ack_o dropped while req_i was still high", idx);
        other_errors++;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    wait_ack(1'b0, idx);
    in_handshake = 1'b0;
  endtask

  initial begin
    rst_n           = 1'b0;
    req             = 1'b0;
    cmd             = '0;
    in_handshake    = 1'b0;
    seed            = 32'hb916_20c7;
    value_errors    = 0;
    other_errors    = 0;
    stray_acks      = 0;
    wait (loaded === 1'b1);
    if (nr_vectors == 0) begin
      $display("No vectors were found in bench/vec_vectors.txt");
      other_errors++;
    end
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < nr_vectors; i++) begin
      apply_vector(i);
    end
    repeat (4) @(posedge clk);
    print_counts();
    if ((value_errors + other_errors + stray_acks) == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (loaded === 1'b1);
    repeat (reset_cycles + (nr_vectors + 1) * cycles_per_vector) @(posedge clk);
    $display("Watchdog timeout: %0d vectors did not finish in time", nr_vectors);
    print_counts();
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/vec_vectors.txt
// op vd vs1 vs2 scalar exp_data exp_vl, all hex, one host command per line
// op f ends the list
0 0 0 0 0000 0000 00
8 0 0 1 0000 0000 00
0 0 0 0 0005 0005 05
0 0 0 0 0028 0010 10
1 1 0 0 1234 0000 10
7 0 0 1 0000 1234 10
7 0 0 1 0007 1234 10
7 0 0 1 000f 1234 10
7 0 0 1 0010 0000 10
1 2 0 0 f00f 0000 10
2 3 2 1 0000 0000 10
3 4 2 1 0000 0000 10
4 5 2 1 0000 0000 10
5 6 2 1 0000 0000 10
6 7 0 2 2000 0000 10
7 0 0 3 0003 0243 10
7 0 0 4 000c 2225 10
7 0 0 5 0009 1004 10
7 0 0 6 000e e23b 10
7 0 0 7 0005 100f 10
8 0 0 1 0000 2340 10
1 0 0 0 aaaa 0000 10
0 0 0 0 0006 0006 06
1 0 0 0 5555 0000 06
7 0 0 0 0005 5555 06
7 0 0 0 0006 0000 06
8 0 0 0 0000 fffe 06
0 0 0 0 0010 0010 10
7 0 0 0 0006 aaaa 10
8 0 0 0 0000 aaa2 10
f 0 0 0 0000 0000 00

// File: tb.f
design/vec_cfg_pkg.sv
design/vec_insn_pkg.sv
design/vec_csr.sv
design/vec_dispatcher.sv
design/vec_sequencer.sv
design/vec_lane.sv
design/vec_top.sv
bench/tb_vec_top.sv

// File: run.sh
#!/bin/sh
# Build and run the vector coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj_dir=obj_dir

verilator --binary --assert -Wno-fatal --top-module tb_vec_top \
  --Mdir "$obj_dir" -o vsim -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$obj_dir/vsim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
